// File: common/cap_defines.svh
`ifndef CAP_DEFINES_SVH
`define CAP_DEFINES_SVH

// adc sample and packed word widths
`define CAP_SAMPLE_W 12
`define CAP_WORD_W 64

// downsample field and kept-sample counter
`define CAP_DS_W 13
`define CAP_COUNT_W 16

// 16 samples of 12 bits fill exactly three 64-bit words
`define CAP_GROUP_SAMPLES 16

// a capture that never leaves this window is flagged as low gain
`define CAP_QUIET_LO 12'd1792
`define CAP_QUIET_HI 12'd2559

`endif

// File: common/cap_pkg.sv
`default_nettype none

package cap_pkg;

    // capture FSM states
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        ARMED     = 2'd1,
        TRIGGERED = 2'd2,
        DONE      = 2'd3
    } capture_state_e;

    // one flag per error source, sticky in the status block
    typedef struct packed {
        logic trigger_ignored;  // go edge seen while idle
        logic clip;             // sample hit 0 or full scale
        logic gain_low;         // whole capture stayed near mid-scale
    } err_stat_t;

endpackage

`default_nettype wire

// File: common/sample_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "cap_defines.svh"

// kept-sample stream from the capture FSM to the packer and the monitor
// no back-pressure, sinks take every strobe
interface sample_if;
    logic                     strobe;  // high one cycle per kept sample
    logic [`CAP_SAMPLE_W-1:0] data;    // valid while strobe is high
    logic                     first;   // first kept sample of a capture
    logic                     last;    // max_samples-th kept sample

    modport source (
        output strobe,
        output data,
        output first,
        output last
    );

    modport sink (
        input strobe,
        input data,
        input first,
        input last
    );
endinterface

`default_nettype wire

// File: monitor/sample_monitor.sv
`timescale 1ns/1ns
`default_nettype none
`include "cap_defines.svh"

module sample_monitor (
    input  wire    adc_sampleclk,
    input  wire    reset,
    sample_if.sink smp,
    output logic   clip_err_o,
    output logic   gain_err_o
);

    logic gain_low;      // every sample so far sat in the quiet window
    logic gain_low_nxt;
    logic quiet;

    assign quiet = (smp.data >= `CAP_QUIET_LO) && (smp.data <= `CAP_QUIET_HI);

    // the first sample restarts the check for a new capture
    assign gain_low_nxt = (smp.first || gain_low) && quiet;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            gain_low   <= 1'b0;
            clip_err_o <= 1'b0;
            gain_err_o <= 1'b0;
        end else begin
            // rail hit at either end of the adc range
            clip_err_o <= smp.strobe && ((smp.data == '0) || (smp.data == '1));
            gain_err_o <= smp.strobe && smp.last && gain_low_nxt;
            if (smp.strobe)
                gain_low <= gain_low_nxt;
        end
    end

endmodule

`default_nettype wire

// File: packer/word_packer.sv
`timescale 1ns/1ns
`default_nettype none
`include "cap_defines.svh"

module word_packer (
    input  wire                    adc_sampleclk,
    input  wire                    reset,
    sample_if.sink                 smp,
    output logic [`CAP_WORD_W-1:0] word_o,
    output logic                   word_valid_o,
    output logic                   final_word_o
);

    localparam int SHIFT_W = 6 * `CAP_SAMPLE_W;  // six samples, one straddles two words
    localparam int GRP_W   = $clog2(`CAP_GROUP_SAMPLES);

    logic [SHIFT_W-1:0]       shifter;
    logic [SHIFT_W-1:0]       shifter_nxt;
    logic [`CAP_SAMPLE_W-1:0] din;
    logic [GRP_W-1:0]         grp_cnt;  // sample position in the 16-sample group
    logic [GRP_W-1:0]         grp_pos;
    logic [1:0]               phase;    // which of the three words is being filled
    logic [1:0]               phase_pos;
    logic                     filling;  // padding the last group with zeros
    logic                     take;
    logic                     restart;
    logic                     word_done;
    logic                     group_done;

    assign restart = smp.strobe && smp.first;
    assign take    = smp.strobe || filling;
    assign din     = smp.strobe ? smp.data : '0;  // filler samples are zero

    assign grp_pos   = restart ? '0 : grp_cnt;
    assign phase_pos = restart ? 2'd0 : phase;

    // words close after samples 6, 11 and 16 of the group
    assign group_done = (grp_pos == GRP_W'(`CAP_GROUP_SAMPLES - 1));
    assign word_done  = (grp_pos == GRP_W'(5)) || (grp_pos == GRP_W'(10)) || group_done;

    assign shifter_nxt = {shifter[SHIFT_W-`CAP_SAMPLE_W-1:0], din};

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            grp_cnt      <= '0;
            phase        <= 2'd0;
            filling      <= 1'b0;
            word_valid_o <= 1'b0;
            final_word_o <= 1'b0;
        end else begin
            word_valid_o <= take && word_done;
            final_word_o <= take && group_done && (filling || (smp.strobe && smp.last));

            if (take) begin
                grp_cnt <= group_done ? '0 : grp_pos + 1'b1;
                if (word_done)
                    phase <= (phase_pos == 2'd2) ? 2'd0 : phase_pos + 2'd1;
                else
                    phase <= phase_pos;
            end

            if (smp.strobe && smp.last)
                filling <= !group_done;  // no filler on an exact boundary
            else if (restart || (take && group_done))
                filling <= 1'b0;
        end
    end

    // msb-first, oldest sample at the top of the word
    always_ff @(posedge adc_sampleclk) begin
        if (take)
            shifter <= shifter_nxt;
        if (take && word_done) begin
            case (phase_pos)
                2'd0:    word_o <= shifter_nxt[SHIFT_W-1 -: `CAP_WORD_W];  // 5 samples + 4 bits
                2'd1:    word_o <= shifter_nxt[SHIFT_W-5 -: `CAP_WORD_W];  // 8 + 4 samples + 8
                default: word_o <= shifter_nxt[`CAP_WORD_W-1:0];           // 4 bits + 5 samples
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/adc_capture_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "cap_defines.svh"

module adc_capture_top (
    input  wire                     adc_sampleclk,
    input  wire                     reset,
    input  wire [`CAP_SAMPLE_W-1:0] adc_data_i,
    input  wire                     arm_i,
    input  wire                     capture_go_i,
    input  wire [`CAP_DS_W-1:0]     downsample_i,
    input  wire [`CAP_COUNT_W-1:0]  max_samples_i,
    input  wire                     clear_errors_i,
    output logic [`CAP_WORD_W-1:0]  word_o,
    output logic                    word_valid_o,
    output logic                    capture_done_o,
    output logic                    armed_o,
    output logic                    error_flag_o,
    output cap_pkg::err_stat_t      error_stat_o,
    output cap_pkg::err_stat_t      first_error_stat_o,
    output cap_pkg::capture_state_e state_o
);

    wire arm_pulse;
    wire trig_ignored;
    wire clip_err;
    wire gain_err;
    wire final_word;

    sample_if smp ();  // kept samples, fanned out to packer and monitor

    capture_ctrl u_capture_ctrl (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_data_i     (adc_data_i),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .downsample_i   (downsample_i),
        .max_samples_i  (max_samples_i),
        .smp            (smp),
        .arm_pulse_o    (arm_pulse),
        .trig_ignored_o (trig_ignored),
        .armed_o        (armed_o),
        .state_o        (state_o)
    );

    word_packer u_word_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .smp           (smp),
        .word_o        (word_o),
        .word_valid_o  (word_valid_o),
        .final_word_o  (final_word)
    );

    sample_monitor u_sample_monitor (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .smp           (smp),
        .clip_err_o    (clip_err),
        .gain_err_o    (gain_err)
    );

    capture_status u_capture_status (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .clear_errors_i     (clear_errors_i),
        .arm_pulse_i        (arm_pulse),
        .trig_ignored_i     (trig_ignored),
        .clip_err_i         (clip_err),
        .gain_err_i         (gain_err),
        .final_word_i       (final_word),
        .capture_done_o     (capture_done_o),
        .error_flag_o       (error_flag_o),
        .error_stat_o       (error_stat_o),
        .first_error_stat_o (first_error_stat_o)
    );

endmodule

`default_nettype wire

// File: rtl/capture_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "cap_defines.svh"

module capture_ctrl (
    input  wire                     adc_sampleclk,
    input  wire                     reset,
    input  wire [`CAP_SAMPLE_W-1:0] adc_data_i,
    input  wire                     arm_i,
    input  wire                     capture_go_i,
    input  wire [`CAP_DS_W-1:0]     downsample_i,
    input  wire [`CAP_COUNT_W-1:0]  max_samples_i,
    sample_if.source                smp,
    output logic                    arm_pulse_o,
    output logic                    trig_ignored_o,
    output logic                    armed_o,
    output cap_pkg::capture_state_e state_o
);

    cap_pkg::capture_state_e state;
    logic                    arm_r;
    logic                    go_r;
    logic                    arm_rise;
    logic                    go_rise;
    logic [`CAP_DS_W-1:0]    ds_ctr;     // cycles since the last kept sample
    logic [`CAP_COUNT_W-1:0] sample_cnt; // kept samples issued so far
    logic                    keep;

    assign arm_rise = arm_i & ~arm_r;
    assign go_rise  = capture_go_i & ~go_r;

    // first kept sample sits on the trigger edge, the rest follow the downsample wrap
    assign keep = ((state == cap_pkg::ARMED) && go_rise) ||
                  ((state == cap_pkg::TRIGGERED) && (ds_ctr == downsample_i) &&
                   (sample_cnt != max_samples_i));

    assign armed_o = (state == cap_pkg::ARMED);
    assign state_o = state;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state          <= cap_pkg::IDLE;
            arm_r          <= 1'b0;
            go_r           <= 1'b0;
            arm_pulse_o    <= 1'b0;
            trig_ignored_o <= 1'b0;
            smp.strobe     <= 1'b0;
            ds_ctr         <= '0;
            sample_cnt     <= '0;
        end else begin
            arm_r          <= arm_i;
            go_r           <= capture_go_i;
            arm_pulse_o    <= arm_rise;
            trig_ignored_o <= go_rise && (state == cap_pkg::IDLE);
            smp.strobe     <= keep && !arm_rise;

            if (arm_rise) begin
                // arming also cuts short a running capture
                state      <= cap_pkg::ARMED;
                ds_ctr     <= '0;
                sample_cnt <= '0;
            end else begin
                if (keep) begin
                    ds_ctr     <= '0;
                    sample_cnt <= sample_cnt + 1'b1;
                end else if (state == cap_pkg::TRIGGERED) begin
                    ds_ctr <= ds_ctr + 1'b1;
                end

                case (state)
                    cap_pkg::ARMED:
                        if (go_rise)
                            state <= cap_pkg::TRIGGERED;
                    cap_pkg::TRIGGERED:
                        if (smp.strobe && smp.last)
                            state <= cap_pkg::DONE;  // last strobe is out
                    cap_pkg::DONE:
                        state <= cap_pkg::IDLE;
                    default:
                        state <= state;  // idle waits for an arm edge
                endcase
            end
        end
    end

    // sample payload, only meaningful while strobe is high
    always_ff @(posedge adc_sampleclk) begin
        if (keep) begin
            smp.data  <= adc_data_i;
            smp.first <= (state == cap_pkg::ARMED);
            smp.last  <= (sample_cnt == max_samples_i - 1'b1);
        end
    end

endmodule

`default_nettype wire

// File: rtl/capture_status.sv
`timescale 1ns/1ns
`default_nettype none

module capture_status (
    input  wire                adc_sampleclk,
    input  wire                reset,
    input  wire                clear_errors_i,
    input  wire                arm_pulse_i,
    input  wire                trig_ignored_i,
    input  wire                clip_err_i,
    input  wire                gain_err_i,
    input  wire                final_word_i,
    output logic               capture_done_o,
    output logic               error_flag_o,
    output cap_pkg::err_stat_t error_stat_o,
    output cap_pkg::err_stat_t first_error_stat_o
);

    cap_pkg::err_stat_t new_bits;
    logic               any_err;

    // error strobes seen this cycle
    always_comb begin
        new_bits.trigger_ignored = trig_ignored_i;
        new_bits.clip            = clip_err_i;
        new_bits.gain_low        = gain_err_i;
    end

    assign any_err = |new_bits;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            capture_done_o     <= 1'b0;
            error_flag_o       <= 1'b0;
            error_stat_o       <= '0;
            first_error_stat_o <= '0;
        end else if (arm_pulse_i || clear_errors_i) begin
            // a new arm starts from a clean status
            capture_done_o     <= 1'b0;
            error_flag_o       <= 1'b0;
            error_stat_o       <= '0;
            first_error_stat_o <= '0;
        end else begin
            if (final_word_i)
                capture_done_o <= 1'b1;

            error_stat_o <= error_stat_o | new_bits;  // older bits stay set

            if (any_err) begin
                error_flag_o <= 1'b1;
                if (!error_flag_o)
                    first_error_stat_o <= new_bits;  // snapshot of the earliest error
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the adc capture testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sources.f --top-module tb_adc_capture -Mdir obj_dir -o sim_adc_capture
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_adc_capture)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1

// File: sources.f
+incdir+common
common/cap_pkg.sv
common/sample_if.sv
rtl/capture_ctrl.sv
packer/word_packer.sv
monitor/sample_monitor.sv
rtl/capture_status.sv
rtl/adc_capture_top.sv
tests/adc_capture_properties.sv
tests/tb_adc_capture.sv

// File: tests/adc_capture_properties.sv
`timescale 1ns/1ns
`default_nettype none
`include "cap_defines.svh"

module adc_capture_properties (
    input wire                 adc_sampleclk,
    input wire                 reset,
    input wire [`CAP_DS_W-1:0] downsample_i,
    input wire                 word_valid_i,
    input wire                 strobe_i,
    input wire [1:0]           state_i
);

    // a downsampled stream can never close two words back to back
    property word_valid_spaced;
        @(posedge adc_sampleclk) disable iff (reset)
            (word_valid_i && (downsample_i != '0)) |=> !word_valid_i;
    endproperty

    property strobe_in_triggered;
        @(posedge adc_sampleclk) disable iff (reset)
            strobe_i |-> (state_i == cap_pkg::TRIGGERED);
    endproperty

    assert property (word_valid_spaced)
        else $error("word_valid_o high on two consecutive cycles with downsampling");

    assert property (strobe_in_triggered)
        else $error("sample strobe outside the TRIGGERED state");

endmodule

// top level sees both the packer output and the sample stream
bind adc_capture_top adc_capture_properties u_properties (
    .adc_sampleclk (adc_sampleclk),
    .reset         (reset),
    .downsample_i  (downsample_i),
    .word_valid_i  (word_valid_o),
    .strobe_i      (smp.strobe),
    .state_i       (state_o)
);

`default_nettype wire

// File: tests/tb_adc_capture.sv
`timescale 1ns/1ns
`default_nettype none
`include "cap_defines.svh"

module tb_adc_capture;

    localparam int WAIT_LIMIT   = 1000;  // cycles before a wait gives up
    localparam int COND_ARMED   = 0;
    localparam int COND_DONE    = 1;
    localparam int COND_IGNORED = 2;
    localparam int COND_CLEARED = 3;

    logic                     adc_sampleclk = 1'b0;
    logic                     reset         = 1'b1;
    logic [`CAP_SAMPLE_W-1:0] adc_data      = '0;
    logic                     arm           = 1'b0;
    logic                     capture_go    = 1'b0;
    logic [`CAP_DS_W-1:0]     downsample    = '0;
    logic [`CAP_COUNT_W-1:0]  max_samples   = '0;
    logic                     clear_errors  = 1'b0;
    logic [`CAP_WORD_W-1:0]   word;
    logic                     word_valid;
    logic                     capture_done;
    logic                     armed;
    logic                     error_flag;
    cap_pkg::err_stat_t       error_stat;
    cap_pkg::err_stat_t       first_error_stat;
    cap_pkg::capture_state_e  state;

    logic                     seed_req  = 1'b0;  // load seed_val into the ramp
    logic [`CAP_SAMPLE_W-1:0] seed_val  = '0;
    logic [`CAP_SAMPLE_W-1:0] ramp_step = 12'd1;
    logic [`CAP_SAMPLE_W-1:0] go_data   = '0;    // adc value on the edge that sees go high

    logic [`CAP_WORD_W-1:0] words[$];  // packed words seen since the test began
    integer                 seed = 17491;
    int                     checks = 0;
    int                     errors = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     errors_at_start = 0;

    always #2 adc_sampleclk = ~adc_sampleclk;

    adc_capture_top UUT (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .adc_data_i         (adc_data),
        .arm_i              (arm),
        .capture_go_i       (capture_go),
        .downsample_i       (downsample),
        .max_samples_i      (max_samples),
        .clear_errors_i     (clear_errors),
        .word_o             (word),
        .word_valid_o       (word_valid),
        .capture_done_o     (capture_done),
        .armed_o            (armed),
        .error_flag_o       (error_flag),
        .error_stat_o       (error_stat),
        .first_error_stat_o (first_error_stat),
        .state_o            (state)
    );

    // adc model, a ramp that moves by ramp_step every cycle
    always @(posedge adc_sampleclk) begin
        if (seed_req)
            adc_data <= seed_val;
        else
            adc_data <= adc_data + ramp_step;
    end

    always @(posedge adc_sampleclk) begin
        if (!reset && word_valid)
            words.push_back(word);
    end

    function automatic logic condition_met(input int kind);
        case (kind)
            COND_ARMED:   return armed;
            COND_DONE:    return capture_done;
            COND_IGNORED: return error_stat.trigger_ignored;
            default:      return !error_flag && !capture_done;
        endcase
    endfunction

    // sample k of the capture, sample 0 at the top of the first word
    function automatic logic [`CAP_SAMPLE_W-1:0] unpacked_sample(input int k);
        logic [`CAP_SAMPLE_W-1:0] s;
        logic [`CAP_WORD_W-1:0]   shifted;
        int                       pos;
        int                       i;
        s = '0;
        for (i = 0; i < `CAP_SAMPLE_W; i++) begin
            pos = k * `CAP_SAMPLE_W + i;  // bit position in the stream, msb first
            shifted = '0;
            if (pos / `CAP_WORD_W < words.size())
                shifted = words[pos / `CAP_WORD_W] >> (`CAP_WORD_W - 1 - pos % `CAP_WORD_W);
            s = {s[`CAP_SAMPLE_W-2:0], shifted[0]};
        end
        return s;
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic wait_until(input int kind, input string what);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge adc_sampleclk);
            if (condition_met(kind))
                return;
        end
        errors++;
        $display("timeout at %0t ns: %s did not happen within %0d cycles",
                 $time, what, WAIT_LIMIT);
    endtask

    task automatic reseed_ramp(input logic [`CAP_SAMPLE_W-1:0] start,
                               input logic [`CAP_SAMPLE_W-1:0] step);
        @(posedge adc_sampleclk);
        seed_req  <= 1'b1;
        seed_val  <= start;
        ramp_step <= step;
        @(posedge adc_sampleclk);
        seed_req <= 1'b0;
    endtask

    task automatic pulse_go();
        @(posedge adc_sampleclk);
        capture_go <= 1'b1;
        @(posedge adc_sampleclk);
        go_data     = adc_data;  // the trigger edge registers this value
        capture_go <= 1'b0;
    endtask

    task automatic start_capture(input int ds, input int count);
        @(posedge adc_sampleclk);
        downsample  <= `CAP_DS_W'(ds);
        max_samples <= `CAP_COUNT_W'(count);
        arm         <= 1'b1;
        @(posedge adc_sampleclk);
        arm <= 1'b0;
        wait_until(COND_ARMED, "armed_o rising");
        pulse_go();
    endtask

    // kept sample i is the ramp value at the trigger edge plus i steps
    task automatic check_ramp(input int count, input int step, input string what);
        int i;
        for (i = 0; i < count; i++)
            check(64'(unpacked_sample(i)), 64'(`CAP_SAMPLE_W'(go_data + i * step)),
                  $sformatf("%s sample %0d", what, i));
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        words.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
    endtask

    task automatic reset_values();
        begin_test();
        check(64'(word_valid), 64'd0, "word_valid_o after reset");
        check(64'(capture_done), 64'd0, "capture_done_o after reset");
        check(64'(armed), 64'd0, "armed_o after reset");
        check(64'(error_flag), 64'd0, "error_flag_o after reset");
        check(64'(state), 64'(cap_pkg::IDLE), "state after reset");
        end_test("reset_values");
    endtask

    task automatic plain_capture();
        begin_test();
        reseed_ramp(`CAP_SAMPLE_W'($random(seed)), 12'd1);
        start_capture(0, 32);
        wait_until(COND_DONE, "capture_done_o rising");
        check(64'(words.size()), 64'd6, "word count for 32 samples");
        check_ramp(32, 1, "plain");
        check(64'(state), 64'(cap_pkg::IDLE), "state after capture_done_o");
        end_test("plain_capture");
    endtask

    task automatic padded_capture();
        int i;
        begin_test();
        reseed_ramp(`CAP_SAMPLE_W'($random(seed)), 12'd1);
        start_capture(0, 20);
        wait_until(COND_DONE, "capture_done_o rising");
        check(64'(words.size()), 64'd6, "word count for 20 samples");
        check_ramp(20, 1, "padded");
        for (i = 20; i < 2 * `CAP_GROUP_SAMPLES; i++)
            check(64'(unpacked_sample(i)), 64'd0, $sformatf("filler sample %0d", i));
        end_test("padded_capture");
    endtask

    task automatic downsampled_capture();
        begin_test();
        reseed_ramp(`CAP_SAMPLE_W'($random(seed)), 12'd1);
        start_capture(3, 16);
        wait_until(COND_DONE, "capture_done_o rising");
        check(64'(words.size()), 64'd3, "word count with downsample 3");
        check_ramp(16, 4, "downsampled");
        end_test("downsampled_capture");
    endtask

    task automatic error_status();
        begin_test();
        // ramp runs through full scale and wraps to zero
        reseed_ramp(12'd4080, 12'd1);
        start_capture(0, 32);
        wait_until(COND_DONE, "capture_done_o after the clipping capture");
        check(64'(error_stat), 64'b010, "error status after clipping");
        check(64'(first_error_stat), 64'b010, "first error after clipping");
        check(64'(error_flag), 64'd1, "error_flag_o after clipping");

        reseed_ramp(12'd2048, 12'd0);  // flat mid-scale input
        start_capture(0, 16);
        wait_until(COND_DONE, "capture_done_o after the quiet capture");
        check(64'(error_stat), 64'b001, "error status after quiet capture");
        check(64'(first_error_stat), 64'b001, "first error after quiet capture");

        pulse_go();  // state is idle again
        wait_until(COND_IGNORED, "trigger_ignored status bit");
        check(64'(error_stat), 64'b101, "error status after ignored trigger");
        check(64'(first_error_stat), 64'b001, "first error keeps the earliest bit");

        @(posedge adc_sampleclk);
        clear_errors <= 1'b1;
        @(posedge adc_sampleclk);
        clear_errors <= 1'b0;
        wait_until(COND_CLEARED, "status clear");
        check(64'(error_stat), 64'd0, "error status after clear");
        check(64'(first_error_stat), 64'd0, "first error after clear");
        check(64'(capture_done), 64'd0, "capture_done_o after clear");
        end_test("error_status");
    endtask

    task automatic ignored_trigger();
        int n;
        begin_test();
        // low start value keeps this capture free of clip and gain errors
        reseed_ramp(`CAP_SAMPLE_W'(100 + ($random(seed) & 511)), 12'd1);
        start_capture(0, 16);
        wait_until(COND_DONE, "capture_done_o rising");
        words.delete();
        pulse_go();
        wait_until(COND_IGNORED, "trigger_ignored status bit");
        check(64'(error_stat), 64'b100, "error status after go while idle");
        for (n = 0; n < 200; n++)
            @(posedge adc_sampleclk);
        check(64'(words.size()), 64'd0, "words after an ignored trigger");

        @(posedge adc_sampleclk);
        arm <= 1'b1;
        @(posedge adc_sampleclk);
        arm <= 1'b0;
        wait_until(COND_CLEARED, "status clear on re-arm");
        check(64'(error_stat), 64'd0, "error status after re-arm");
        check(64'(capture_done), 64'd0, "capture_done_o after re-arm");
        check(64'(armed), 64'd1, "armed_o after re-arm");
        end_test("ignored_trigger");
    endtask

    initial begin
        repeat (16) @(posedge adc_sampleclk);
        reset <= 1'b0;
        @(posedge adc_sampleclk);

        reset_values();
        plain_capture();
        padded_capture();
        downsampled_capture();
        error_status();
        ignored_trigger();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
